/* Makefile */
# Verilator flow for the VGA controller testbench

LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal --top-module vga_tb -Mdir obj_dir -f sim.f

run: build
	./obj_dir/Vvga_tb > $(LOG) 2>&1; cat $(LOG)
	grep -qx "test passed" $(LOG)

lint:
	verilator --lint-only -Wall --timing --top-module vga_tb -f sim.f

clean:
	rm -rf obj_dir $(LOG)

/* bench/vga_tb_model.svh */
`ifndef VGA_TB_MODEL_SVH
`define VGA_TB_MODEL_SVH

task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
        $display("FAILED at %0d ns: %s, got %0h, expected %0h", $time, what, got, exp);
        $display("test failed");
        $fatal(1, "value mismatch");
    end
endtask

// 16-colour EGA set with levels 0..3 per channel
function automatic logic [5:0] ega_colour(input logic [3:0] idx);
    logic [1:0] on_lvl;
    logic [1:0] off_lvl;
    logic [1:0] r_lvl;
    logic [1:0] g_lvl;
    logic [1:0] b_lvl;
    on_lvl  = idx[3] ? 2'd3 : 2'd2;
    off_lvl = idx[3] ? 2'd1 : 2'd0;
    r_lvl   = idx[2] ? on_lvl : off_lvl;
    g_lvl   = idx[1] ? on_lvl : off_lvl;
    b_lvl   = idx[0] ? on_lvl : off_lvl;
    // brown, not dark yellow
    if (idx == 4'd6)
        g_lvl = 2'd1;
    return {r_lvl, g_lvl, b_lvl};
endfunction

function automatic logic [5:0] expected_rgb(input vga_timing_pkg::vga_mode_t md,
                                            input logic [18:0] fb, input logic [18:0] ft,
                                            input int x, input int y);
    logic [18:0] adr;
    logic [18:0] next_adr;
    logic [7:0]  attr;
    logic [7:0]  font;
    logic [7:0]  byte_val;
    logic        fg;
    case (md)
        vga_timing_pkg::mode_text_40: begin
            // char and attr pairs in cells 16 pixels wide and 16 lines high
            adr      = fb + 19'((y / 16) * 2 * (h_vis / 16) + 2 * (x / 16));
            next_adr = adr + 19'd1;
            attr     = mem[next_adr];
            font     = mem[ft + 19'({mem[adr], 3'((y % 16) / 2)})];
            fg       = font[7 - (x % 16) / 2];
            return ega_colour(fg ? attr[7:4] : attr[3:0]);
        end
        vga_timing_pkg::mode_gfx_640: begin
            byte_val = mem[fb + 19'(y * (h_vis / 2) + x / 2)];
            return ega_colour((x % 2 == 1) ? byte_val[3:0] : byte_val[7:4]);
        end
        vga_timing_pkg::mode_gfx_320: begin
            byte_val = mem[fb + 19'((y / 2) * (h_vis / 2) + x / 2)];
            return byte_val[5:0];
        end
        default: return 6'd0;
    endcase
endfunction

`endif

/* bench/vga_tb.sv */
`timescale 1ns/1ps

module vga_tb;

    localparam int h_vis   = 64;
    localparam int h_front = 4;
    localparam int h_pulse = 8;
    localparam int h_back  = 16;
    localparam int v_vis   = 32;
    localparam int v_front = 2;
    localparam int v_pulse = 2;
    localparam int v_back  = 3;
    localparam int h_total = h_vis + h_front + h_pulse + h_back;
    localparam int v_total = v_vis + v_front + v_pulse + v_back;
    // blank frame and register traffic plus up to two frames per mode
    localparam int cycle_limit = 8 * h_total * v_total;

    logic                  I_vga_clk;
    logic                  I_reset;
    vga_bus_pkg::wb_req_t  wb_in;
    vga_bus_pkg::wb_rsp_t  wb_out;
    vga_bus_pkg::ram_req_t ram;
    logic [7:0]            ram_dat = 8'h00;
    logic                  hsync;
    logic                  vsync;
    logic [1:0]            r;
    logic [1:0]            g;
    logic [1:0]            b;

    logic [7:0]  mem [0:524287];
    logic [18:0] pend_adr;
    logic        pending = 1'b0;
    int          req_count = 0;
    int          cycles = 0;
    int          seed;
    int          h_cnt = 0;
    int          v_cnt = 0;
    logic        h_seen = 1'b0;
    logic        v_seen = 1'b0;
    logic        h_prev = 1'b1;
    logic        v_prev = 1'b1;

    `include "vga_tb_model.svh"

    vga_top #(
        .h_visible (h_vis), .h_front (h_front), .h_pulse (h_pulse), .h_back (h_back),
        .v_visible (v_vis), .v_front (v_front), .v_pulse (v_pulse), .v_back (v_back)
    ) dut (
        .I_vga_clk (I_vga_clk),
        .I_reset   (I_reset),
        .wb_in     (wb_in),
        .wb_out    (wb_out),
        .ram       (ram),
        .ram_dat   (ram_dat),
        .hsync     (hsync),
        .vsync     (vsync),
        .r         (r),
        .g         (g),
        .b         (b)
    );

    initial begin
        I_vga_clk = 1'b0;
        forever #20 I_vga_clk = ~I_vga_clk;
    end

    // external RAM answers one cycle after the request
    always @(negedge I_vga_clk) begin
        if (pending)
            ram_dat = mem[pend_adr];
        pending = (ram.req === 1'b1);
        if (pending) begin
            pend_adr  = ram.adr;
            req_count = req_count + 1;
        end
    end

    // sync widths and periods
    always @(negedge I_vga_clk) begin
        if (!I_reset) begin
            h_cnt = h_cnt + 1;
            v_cnt = v_cnt + 1;
            if (h_prev && !hsync) begin
                if (h_seen)
                    check_value(h_cnt, h_total, "hsync period");
                h_seen = 1'b1;
                h_cnt  = 0;
            end
            if (!h_prev && hsync && h_seen)
                check_value(h_cnt, h_pulse, "hsync low width");
            if (v_prev && !vsync) begin
                if (v_seen)
                    check_value(v_cnt, v_total * h_total, "vsync period");
                v_seen = 1'b1;
                v_cnt  = 0;
            end
            if (!v_prev && vsync && v_seen)
                check_value(v_cnt, v_pulse * h_total, "vsync low width");
            h_prev = hsync;
            v_prev = vsync;
        end
    end

    always @(posedge I_vga_clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: no result after %0d clock cycles", cycle_limit);
            $display("test failed");
            $fatal(1, "simulation timeout");
        end
    end

    task automatic wb_write(input logic [3:0] adr, input logic [7:0] dat);
        wb_in.cyc = 1'b1;
        wb_in.stb = 1'b1;
        wb_in.we  = 1'b1;
        wb_in.adr = adr;
        wb_in.dat = dat;
        do @(negedge I_vga_clk); while (wb_out.ack !== 1'b1);
        wb_in = '0;
    endtask

    task automatic wb_read(input logic [3:0] adr, output logic [7:0] dat);
        wb_in.cyc = 1'b1;
        wb_in.stb = 1'b1;
        wb_in.we  = 1'b0;
        wb_in.adr = adr;
        wb_in.dat = 8'h00;
        do @(negedge I_vga_clk); while (wb_out.ack !== 1'b1);
        dat   = wb_out.dat;
        wb_in = '0;
    endtask

    // three staged bytes followed by the commit address
    task automatic write_base(input logic [3:0] first, input logic [23:0] val);
        wb_write(first, val[7:0]);
        wb_write(first + 4'd1, val[15:8]);
        wb_write(first + 4'd2, val[23:16]);
        wb_write(first + 4'd3, 8'h00);
    endtask

    task automatic read_base(input logic [3:0] first, output logic [23:0] val);
        logic [7:0] lo;
        logic [7:0] mid;
        logic [7:0] hi;
        wb_read(first, lo);
        wb_read(first + 4'd1, mid);
        wb_read(first + 4'd2, hi);
        val = {hi, mid, lo};
    endtask

    task automatic wait_hsync_fall();
        do @(negedge I_vga_clk); while (hsync !== 1'b1);
        do @(negedge I_vga_clk); while (hsync !== 1'b0);
    endtask

    task automatic wait_vsync_fall();
        do @(negedge I_vga_clk); while (vsync !== 1'b1);
        do @(negedge I_vga_clk); while (vsync !== 1'b0);
    endtask

    task automatic idle_frame();
        int reqs;
        reqs = req_count;
        repeat (h_total * v_total) begin
            @(negedge I_vga_clk);
            check_value({r, g, b}, 6'd0, "RGB while mode is off");
        end
        check_value(req_count, reqs, "RAM requests while mode is off");
    endtask

    task automatic scan_frame(input vga_timing_pkg::vga_mode_t md,
                              input logic [18:0] fb, input logic [18:0] ft);
        logic [5:0] above [h_vis];
        logic [5:0] px;
        logic       dbl;
        int         reqs;
        int         x;
        int         y;
        wait_vsync_fall();
        // blank lines between the vsync edge and line 0
        repeat (v_pulse + v_back) wait_hsync_fall();
        for (y = 0; y < v_vis; y++) begin
            wait_hsync_fall();
            reqs = req_count;
            dbl  = (md == vga_timing_pkg::mode_gfx_320) && (y % 2 == 1);
            repeat (h_pulse + h_back) @(negedge I_vga_clk);
            for (x = 0; x < h_vis; x++) begin
                @(negedge I_vga_clk);
                px = {r, g, b};
                if (dbl)
                    check_value(px, above[x], $sformatf("doubled line x %0d y %0d", x, y));
                check_value(px, expected_rgb(md, fb, ft, x, y),
                            $sformatf("pixel x %0d y %0d mode %0d", x, y, md));
                above[x] = px;
            end
            if (dbl)
                check_value(req_count, reqs, $sformatf("RAM requests on doubled line %0d", y));
        end
    endtask

    task automatic run_mode(input vga_timing_pkg::vga_mode_t md);
        logic [18:0] fb;
        logic [18:0] ft;
        fb = 19'($random(seed));
        ft = 19'($random(seed));
        write_base(vga_bus_pkg::reg_base_lo, 24'(fb));
        write_base(vga_bus_pkg::reg_font_lo, 24'(ft));
        wb_write(vga_bus_pkg::reg_mode, 8'(md));
        scan_frame(md, fb, ft);
    endtask

    initial begin
        logic [7:0]  rd;
        logic [23:0] val;
        logic [23:0] got;
        logic [23:0] last_fb;
        logic [23:0] last_ft;
        int          i;
        seed    = 32'hc5e77b6c;
        I_reset = 1'b1;
        wb_in   = '0;
        for (i = 0; i < 524288; i++)
            mem[i] = 8'($random(seed));
        repeat (4) @(negedge I_vga_clk);
        I_reset = 1'b0;

        wb_read(vga_bus_pkg::reg_mode, rd);
        check_value(rd, 8'(vga_timing_pkg::mode_off), "mode after reset");
        idle_frame();

        for (i = 0; i < 4; i++) begin
            val = 24'($random(seed));
            write_base(vga_bus_pkg::reg_base_lo, val);
            read_base(vga_bus_pkg::reg_base_lo, got);
            last_fb = {5'b0, val[18:0]};
            check_value(got, last_fb, "frame base readback");
            val = 24'($random(seed));
            write_base(vga_bus_pkg::reg_font_lo, val);
            read_base(vga_bus_pkg::reg_font_lo, got);
            last_ft = {5'b0, val[18:0]};
            check_value(got, last_ft, "font base readback");
        end
        // staged bytes alone must not reach the committed bases
        wb_write(vga_bus_pkg::reg_base_lo, 8'($random(seed)));
        wb_write(vga_bus_pkg::reg_base_mid, 8'($random(seed)));
        wb_write(vga_bus_pkg::reg_font_hi, 8'($random(seed)));
        read_base(vga_bus_pkg::reg_base_lo, got);
        check_value(got, last_fb, "frame base after uncommitted writes");
        read_base(vga_bus_pkg::reg_font_lo, got);
        check_value(got, last_ft, "font base after uncommitted writes");

        run_mode(vga_timing_pkg::mode_text_40);
        run_mode(vga_timing_pkg::mode_gfx_640);
        run_mode(vga_timing_pkg::mode_gfx_320);

        $display("test passed");
        $finish;
    end

endmodule

/* sim.f */
+incdir+bench
source/vga_timing_pkg.sv
source/vga_bus_pkg.sv
source/vga_regs.sv
source/vga_timing.sv
source/vga_fetch.sv
source/vga_pixel.sv
source/vga_top.sv
bench/vga_tb.sv

/* source/vga_bus_pkg.sv */
package vga_bus_pkg;

    // wishbone classic, 8-bit data
    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        logic [3:0] adr;
        logic [7:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic       ack;
        logic [7:0] dat;
    } wb_rsp_t;

    // external RAM request, one cycle pulse
    typedef struct packed {
        logic        req;
        logic [18:0] adr;
    } ram_req_t;

    // register map
    localparam logic [3:0] reg_base_lo     = 4'd0;
    localparam logic [3:0] reg_base_mid    = 4'd1;
    localparam logic [3:0] reg_base_hi     = 4'd2;
    localparam logic [3:0] reg_base_commit = 4'd3;
    localparam logic [3:0] reg_font_lo     = 4'd4;
    localparam logic [3:0] reg_font_mid    = 4'd5;
    localparam logic [3:0] reg_font_hi     = 4'd6;
    localparam logic [3:0] reg_font_commit = 4'd7;
    localparam logic [3:0] reg_mode        = 4'd8;

endpackage

/* source/vga_fetch.sv */
`timescale 1ns/1ps

module vga_fetch #(
    parameter int h_visible = 640,
    parameter int h_front   = 16,
    parameter int h_pulse   = 96,
    parameter int h_back    = 48,
    parameter int v_visible = 480,
    parameter int v_front   = 10,
    parameter int v_pulse   = 2,
    parameter int v_back    = 33,
    localparam int h_start  = h_front + h_pulse + h_back,
    localparam int h_total  = h_start + h_visible,
    localparam int v_total  = v_visible + v_front + v_pulse + v_back,
    localparam int cw       = $clog2(h_total),
    localparam int rw       = $clog2(v_total),
    localparam int cache_n  = h_visible / 2,
    localparam int ciw      = $clog2(cache_n),
    localparam int rot      = (h_start / 2) % 8
) (
    input  logic                       I_vga_clk,
    input  logic                       I_reset,
    input  vga_timing_pkg::vga_mode_t  mode,
    input  logic [18:0]                frame_base,
    input  logic [18:0]                font_base,
    input  logic [cw-1:0]              col,
    input  logic [rw-1:0]              row,
    input  logic                       row_vis,
    input  logic                       line_end,
    input  logic                       frame_end,
    output vga_bus_pkg::ram_req_t      ram,
    input  logic [7:0]                 ram_dat,
    output vga_timing_pkg::fetch_pix_t pix_out
);

    logic [18:0]                line_adr;
    logic [18:0]                font_lat;
    logic [18:0]                cell_adr;
    logic [18:0]                adr_q;
    logic                       req_q;
    logic                       gfx;
    logic                       text;
    logic                       dbl_odd;
    logic [cw-1:0]              g_rel;
    logic [cw-1:0]              t_rel;
    logic                       g_win;
    logic                       g_issue;
    logic                       g_take;
    logic                       t_win;
    logic [3:0]                 t_ph;
    logic [ciw-1:0]             issue_idx;
    logic [ciw-1:0]             take_idx;
    logic [7:0]                 char_q;
    logic [7:0]                 attr_q;
    logic [7:0]                 font_rot;
    logic [7:0]                 cache [cache_n];
    vga_timing_pkg::fetch_pix_t pix_q;

    assign gfx     = (mode == vga_timing_pkg::mode_gfx_640) ||
                     (mode == vga_timing_pkg::mode_gfx_320);
    assign text    = (mode == vga_timing_pkg::mode_text_40);
    assign dbl_odd = (mode == vga_timing_pkg::mode_gfx_320) && row[0];

    // graphics window opens 4 columns ahead of the visible area
    // odd slots issue a request and the data lands two slots later
    assign g_rel     = col - cw'(h_start - 4);
    assign g_win     = gfx && row_vis && (col >= cw'(h_start - 4)) && g_rel[0];
    assign g_issue   = g_win && (g_rel < cw'(h_visible));
    assign g_take    = g_win && (g_rel >= cw'(3)) && (g_rel <= cw'(h_visible + 1));
    assign issue_idx = ciw'(g_rel >> 1);
    assign take_idx  = ciw'((g_rel >> 1) - 1'b1);

    // text cell k is fetched in the 16 columns before it is shown
    assign t_rel    = col - cw'(h_start - 16);
    assign t_win    = text && row_vis && (col >= cw'(h_start - 16)) &&
                      (t_rel < cw'(h_visible));
    assign t_ph     = t_rel[3:0];
    assign cell_adr = line_adr + 19'({t_rel[cw-1:4], 1'b0});

    // align font bits with col[3:1] at the pixel stage
    assign font_rot = 8'({ram_dat, ram_dat} >> rot);

    always_ff @(posedge I_vga_clk) begin
        if (I_reset) begin
            req_q    <= 1'b0;
            line_adr <= '0;
            font_lat <= '0;
        end else begin
            req_q <= (g_issue && !dbl_odd) ||
                     (t_win && (t_ph == 4'd9 || t_ph == 4'd11 || t_ph == 4'd13));
            if (frame_end) begin
                line_adr <= frame_base;
                font_lat <= font_base;
            end else if (line_end && row_vis) begin
                if (text && row[3:0] == 4'hf)
                    line_adr <= line_adr + 19'(h_visible / 8);
                else if (mode == vga_timing_pkg::mode_gfx_640 || dbl_odd)
                    line_adr <= line_adr + 19'(h_visible / 2);
            end
        end
    end

    always_ff @(posedge I_vga_clk) begin
        if (g_issue)
            adr_q <= line_adr + 19'(issue_idx);
        if (t_win) begin
            case (t_ph)
                4'd9: adr_q <= cell_adr;
                4'd11: begin
                    char_q <= ram_dat;
                    adr_q  <= cell_adr + 19'd1;
                end
                4'd13: begin
                    attr_q <= ram_dat;
                    adr_q  <= font_lat + 19'({char_q, row[3:1]});
                end
                4'd15: begin
                    pix_q.font <= font_rot;
                    pix_q.attr <= attr_q;
                end
                default: ;
            endcase
        end
        if (g_take)
            pix_q.pix <= dbl_odd ? cache[take_idx] : ram_dat;
    end

    // line cache for the doubled lines
    always_ff @(posedge I_vga_clk) begin
        if (g_take && !dbl_odd)
            cache[take_idx] <= ram_dat;
    end

    assign ram.req = req_q;
    assign ram.adr = adr_q;
    assign pix_out = pix_q;

endmodule

/* source/vga_pixel.sv */
`timescale 1ns/1ps

module vga_pixel (
    input  logic                       I_vga_clk,
    input  logic                       I_reset,
    input  vga_timing_pkg::vga_mode_t  mode,
    input  vga_timing_pkg::fetch_pix_t pix_in,
    input  logic [3:0]                 col,
    input  logic                       col_vis,
    input  logic                       row_vis,
    output logic [1:0]                 r,
    output logic [1:0]                 g,
    output logic [1:0]                 b
);

    // EGA default palette as {r1, r0, g1, g0, b1, b0}
    localparam logic [5:0] ega [16] = '{
        6'b000000, 6'b000010, 6'b001000, 6'b001010,
        6'b100000, 6'b100010, 6'b100100, 6'b101010,
        6'b010101, 6'b010111, 6'b011101, 6'b011111,
        6'b110101, 6'b110111, 6'b111101, 6'b111111
    };

    logic [3:0] idx;
    logic [5:0] rgb;

    always_comb begin
        case (mode)
            vga_timing_pkg::mode_text_40:
                idx = pix_in.font[3'd7 - col[3:1]] ? pix_in.attr[7:4] : pix_in.attr[3:0];
            vga_timing_pkg::mode_gfx_640:
                idx = col[0] ? pix_in.pix.nib.lo : pix_in.pix.nib.hi;
            default:
                idx = 4'd0;
        endcase
        // 320 mode bypasses the palette
        rgb = (mode == vga_timing_pkg::mode_gfx_320) ? pix_in.pix.dc.rgb : ega[idx];
    end

    always_ff @(posedge I_vga_clk) begin
        if (I_reset)
            {r, g, b} <= 6'b0;
        else
            {r, g, b} <= (col_vis && row_vis) ? rgb : 6'b0;
    end

endmodule

/* source/vga_regs.sv */
`timescale 1ns/1ps

module vga_regs (
    input  logic                      I_vga_clk,
    input  logic                      I_reset,
    input  vga_bus_pkg::wb_req_t      wb_in,
    output vga_bus_pkg::wb_rsp_t      wb_out,
    output vga_timing_pkg::vga_mode_t mode,
    output logic [18:0]               frame_base,
    output logic [18:0]               font_base
);

    logic        ack_q;
    logic [7:0]  rd_dat;
    logic [23:0] stage;
    logic        access;

    // new access only when ack is not already up
    assign access = wb_in.cyc && wb_in.stb && !ack_q;

    always_ff @(posedge I_vga_clk) begin
        if (I_reset) begin
            ack_q      <= 1'b0;
            mode       <= vga_timing_pkg::mode_off;
            frame_base <= '0;
            font_base  <= '0;
        end else begin
            ack_q <= access;
            if (access && wb_in.we) begin
                case (wb_in.adr)
                    vga_bus_pkg::reg_base_lo, vga_bus_pkg::reg_base_mid,
                    vga_bus_pkg::reg_base_hi, vga_bus_pkg::reg_font_lo,
                    vga_bus_pkg::reg_font_mid, vga_bus_pkg::reg_font_hi: ;
                    vga_bus_pkg::reg_base_commit: frame_base <= stage[18:0];
                    vga_bus_pkg::reg_font_commit: font_base <= stage[18:0];
                    default: mode <= vga_timing_pkg::vga_mode_t'(wb_in.dat[1:0]);
                endcase
            end
        end
    end

    // staging bytes shared by both bases
    always_ff @(posedge I_vga_clk) begin
        if (access && wb_in.we) begin
            case (wb_in.adr)
                vga_bus_pkg::reg_base_lo, vga_bus_pkg::reg_font_lo:   stage[7:0] <= wb_in.dat;
                vga_bus_pkg::reg_base_mid, vga_bus_pkg::reg_font_mid: stage[15:8] <= wb_in.dat;
                vga_bus_pkg::reg_base_hi, vga_bus_pkg::reg_font_hi:   stage[23:16] <= wb_in.dat;
                default: ;
            endcase
        end
        if (access && !wb_in.we) begin
            case (wb_in.adr)
                vga_bus_pkg::reg_base_lo:  rd_dat <= frame_base[7:0];
                vga_bus_pkg::reg_base_mid: rd_dat <= frame_base[15:8];
                vga_bus_pkg::reg_base_hi:  rd_dat <= {5'b0, frame_base[18:16]};
                vga_bus_pkg::reg_font_lo:  rd_dat <= font_base[7:0];
                vga_bus_pkg::reg_font_mid: rd_dat <= font_base[15:8];
                vga_bus_pkg::reg_font_hi:  rd_dat <= {5'b0, font_base[18:16]};
                vga_bus_pkg::reg_base_commit, vga_bus_pkg::reg_font_commit: rd_dat <= 8'h00;
                default: rd_dat <= {6'b0, mode};
            endcase
        end
    end

    assign wb_out.ack = ack_q;
    assign wb_out.dat = rd_dat;

endmodule

/* source/vga_timing.sv */
`timescale 1ns/1ps

module vga_timing #(
    parameter int h_visible = 640,
    parameter int h_front   = 16,
    parameter int h_pulse   = 96,
    parameter int h_back    = 48,
    parameter int v_visible = 480,
    parameter int v_front   = 10,
    parameter int v_pulse   = 2,
    parameter int v_back    = 33,
    localparam int h_start  = h_front + h_pulse + h_back,
    localparam int h_total  = h_start + h_visible,
    localparam int v_total  = v_visible + v_front + v_pulse + v_back,
    localparam int cw       = $clog2(h_total),
    localparam int rw       = $clog2(v_total)
) (
    input  logic          I_vga_clk,
    input  logic          I_reset,
    output logic [cw-1:0] col,
    output logic [rw-1:0] row,
    output logic          col_vis,
    output logic          row_vis,
    output logic          line_end,
    output logic          frame_end,
    output logic          hsync,
    output logic          vsync
);

    assign line_end  = (col == cw'(h_total - 1));
    assign frame_end = line_end && (row == rw'(v_total - 1));

    always_ff @(posedge I_vga_clk) begin
        if (I_reset) begin
            col     <= '0;
            row     <= '0;
            col_vis <= 1'b0;
            row_vis <= 1'b1;
            hsync   <= 1'b1;
            vsync   <= 1'b1;
        end else begin
            col <= line_end ? '0 : col + 1'b1;

            if (col == cw'(h_front - 1))
                hsync <= 1'b0;
            else if (col == cw'(h_front + h_pulse - 1))
                hsync <= 1'b1;

            // visible columns sit at the end of the line
            if (col == cw'(h_start - 1))
                col_vis <= 1'b1;
            else if (line_end)
                col_vis <= 1'b0;

            if (line_end) begin
                row <= frame_end ? '0 : row + 1'b1;
                if (frame_end)
                    row_vis <= 1'b1;
                else if (row == rw'(v_visible - 1))
                    row_vis <= 1'b0;
                if (row == rw'(v_visible + v_front - 1))
                    vsync <= 1'b0;
                else if (row == rw'(v_visible + v_front + v_pulse - 1))
                    vsync <= 1'b1;
            end
        end
    end

endmodule

/* source/vga_timing_pkg.sv */
package vga_timing_pkg;

    typedef enum logic [1:0] {
        mode_off     = 2'b00,
        mode_text_40 = 2'b01,
        mode_gfx_640 = 2'b10,
        mode_gfx_320 = 2'b11
    } vga_mode_t;

    // two palette indices, left pixel in the high nibble
    typedef struct packed {
        logic [3:0] hi;
        logic [3:0] lo;
    } pix_nib_t;

    // direct colour byte as {r1, r0, g1, g0, b1, b0}
    typedef struct packed {
        logic [1:0] pad;
        logic [5:0] rgb;
    } pix_dc_t;

    typedef union packed {
        pix_nib_t nib;
        pix_dc_t  dc;
    } pix_byte_u;

    // fetch engine to pixel stage
    typedef struct packed {
        pix_byte_u  pix;
        logic [7:0] font;
        logic [7:0] attr;
    } fetch_pix_t;

endpackage

/* source/vga_top.sv */
`timescale 1ns/1ps

module vga_top #(
    parameter int h_visible = 640,
    parameter int h_front   = 16,
    parameter int h_pulse   = 96,
    parameter int h_back    = 48,
    parameter int v_visible = 480,
    parameter int v_front   = 10,
    parameter int v_pulse   = 2,
    parameter int v_back    = 33,
    localparam int cw = $clog2(h_front + h_pulse + h_back + h_visible),
    localparam int rw = $clog2(v_visible + v_front + v_pulse + v_back)
) (
    input  logic                  I_vga_clk,
    input  logic                  I_reset,
    input  vga_bus_pkg::wb_req_t  wb_in,
    output vga_bus_pkg::wb_rsp_t  wb_out,
    output vga_bus_pkg::ram_req_t ram,
    input  logic [7:0]            ram_dat,
    output logic                  hsync,
    output logic                  vsync,
    output logic [1:0]            r,
    output logic [1:0]            g,
    output logic [1:0]            b
);

    vga_timing_pkg::vga_mode_t  mode;
    vga_timing_pkg::fetch_pix_t fetch_pix;
    logic [18:0]                frame_base;
    logic [18:0]                font_base;
    logic [cw-1:0]              col;
    logic [rw-1:0]              row;
    logic                       col_vis;
    logic                       row_vis;
    logic                       line_end;
    logic                       frame_end;

    vga_regs u_regs (
        .I_vga_clk  (I_vga_clk),
        .I_reset    (I_reset),
        .wb_in      (wb_in),
        .wb_out     (wb_out),
        .mode       (mode),
        .frame_base (frame_base),
        .font_base  (font_base)
    );

    vga_timing #(
        .h_visible (h_visible), .h_front (h_front), .h_pulse (h_pulse), .h_back (h_back),
        .v_visible (v_visible), .v_front (v_front), .v_pulse (v_pulse), .v_back (v_back)
    ) u_timing (
        .I_vga_clk (I_vga_clk),
        .I_reset   (I_reset),
        .col       (col),
        .row       (row),
        .col_vis   (col_vis),
        .row_vis   (row_vis),
        .line_end  (line_end),
        .frame_end (frame_end),
        .hsync     (hsync),
        .vsync     (vsync)
    );

    vga_fetch #(
        .h_visible (h_visible), .h_front (h_front), .h_pulse (h_pulse), .h_back (h_back),
        .v_visible (v_visible), .v_front (v_front), .v_pulse (v_pulse), .v_back (v_back)
    ) u_fetch (
        .I_vga_clk  (I_vga_clk),
        .I_reset    (I_reset),
        .mode       (mode),
        .frame_base (frame_base),
        .font_base  (font_base),
        .col        (col),
        .row        (row),
        .row_vis    (row_vis),
        .line_end   (line_end),
        .frame_end  (frame_end),
        .ram        (ram),
        .ram_dat    (ram_dat),
        .pix_out    (fetch_pix)
    );

    vga_pixel u_pixel (
        .I_vga_clk (I_vga_clk),
        .I_reset   (I_reset),
        .mode      (mode),
        .pix_in    (fetch_pix),
        .col       (col[3:0]),
        .col_vis   (col_vis),
        .row_vis   (row_vis),
        .r         (r),
        .g         (g),
        .b         (b)
    );

endmodule
